// ==== Bender.yml ====
package:
  name: tcb_trace

sources:
  - include_dirs:
      - design
    files:
      - design/tcb_pkg.sv
      - design/tcb_if.sv
      - design/tcb_mem.sv
      - design/tcb_trace_mon.sv
      - design/tcb_trace_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/tcb_trace_checker.sv
      - verification/tcb_trace_tb.sv

// ==== design/tcb_defs.svh ====
// bus and memory sizes; TCB_DW must stay 32 for the RISC-V word view, memory depth a power of two
`ifndef TCB_DEFS_SVH
`define TCB_DEFS_SVH

//////////////////////////////////////////////////
// bus geometry
//////////////////////////////////////////////////

// byte address width
`define TCB_AW 32

// data width, one RISC-V word
`define TCB_DW 32

// one enable per byte lane
`define TCB_BW (`TCB_DW/8)

//////////////////////////////////////////////////
// subordinate and tracer sizes
//////////////////////////////////////////////////

// word count, word index at or above this errors
`define TCB_MEM_WORDS 256

// transfer and error counters, both wrap
`define TCB_CNT_W 16

`endif

// ==== design/tcb_if.sv ====
// single manager TCB, one-cycle request, response valid only in the cycle after acceptance
`timescale 1ns/1ps
`default_nettype none

`include "tcb_defs.svh"

interface tcb_if (
  input logic bus,
  input logic rst_n
);

  // request, from manager
  logic              vld;
  logic              wen;
  logic [`TCB_AW-1:0] adr;
  logic [`TCB_BW-1:0] ben;
  logic [`TCB_DW-1:0] wdt;

  // response, from subordinate
  logic [`TCB_DW-1:0] rdt;
  logic              err;
  // backpressure, low only for write turnaround
  logic              rdy;

  // request side
  modport man (
    input  bus, rst_n,
    output vld, wen, adr, ben, wdt,
    input  rdt, err, rdy
  );

  // memory side
  modport sub (
    input  bus, rst_n,
    input  vld, wen, adr, ben, wdt,
    output rdt, err, rdy
  );

  // observer, never drives
  modport mon (
    input bus, rst_n,
    input vld, wen, adr, ben, wdt,
    input rdt, err, rdy
  );

endinterface

`default_nettype wire

// ==== design/tcb_mem.sv ====
// word memory, low address bits ignored, no reset on contents, rdy drops one cycle per write
`timescale 1ns/1ps
`default_nettype none

`include "tcb_defs.svh"

module tcb_mem (
  tcb_if.sub bus
);

  // index bits of the word array
  localparam int unsigned IW = $clog2(`TCB_MEM_WORDS);

  //////////////////////////////////////////////////
  // storage and address decode
  //////////////////////////////////////////////////

  logic [`TCB_DW-1:0] mem [`TCB_MEM_WORDS];

  // handshake on this edge
  logic               acc;
  // full word index, before range check
  logic [`TCB_AW-3:0] wrd;
  logic               in_rng;
  logic [IW-1:0]      idx;

  assign acc    = bus.vld & bus.rdy;
  // byte offset dropped
  assign wrd    = bus.adr[`TCB_AW-1:2];
  assign in_rng = (wrd < `TCB_MEM_WORDS);
  // truncated index, only used when in range
  assign idx    = wrd[IW-1:0];

  //////////////////////////////////////////////////
  // byte masked write
  //////////////////////////////////////////////////

  // out of range writes leave contents alone
  always_ff @(posedge bus.bus) begin
    if (acc && bus.wen && in_rng) begin
      for (int b = 0; b < `TCB_BW; b++) begin
        // lane b only when enabled
        if (bus.ben[b]) begin
          mem[idx][8*b +: 8] <= bus.wdt[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // response, one cycle after acceptance
  //////////////////////////////////////////////////

  // read data for in range reads only
  // zero on writes, errors and idle cycles
  always_ff @(posedge bus.bus) begin
    if (acc && !bus.wen && in_rng) begin
      bus.rdt <= mem[idx];
    end else begin
      bus.rdt <= '0;
    end
  end

  // err flags the range miss for one cycle
  // rdy low for the cycle after any accepted write,
  // errored writes included
  always_ff @(posedge bus.bus) begin
    if (!bus.rst_n) begin
      bus.err <= 1'b0;
      bus.rdy <= 1'b1;
    end else begin
      bus.err <= acc & ~in_rng;
      bus.rdy <= ~(acc & bus.wen);
    end
  end

  // after a stall rdy returns high by itself,
  // since acc cannot be true while rdy is low

  // a read held through the stall sees the
  // write that caused it

endmodule

`default_nettype wire

// ==== design/tcb_pkg.sv ====
// word views for the tracer only; the instruction view assumes 32-bit RV base encodings
`default_nettype none

`include "tcb_defs.svh"

package tcb_pkg;

  //////////////////////////////////////////////////
  // data word, raw or decoded as an instruction
  //////////////////////////////////////////////////

  // same bits seen two ways
  // raw for data, ins for fetched instructions
  typedef union packed {
    // plain bus data
    logic [`TCB_DW-1:0] raw;
    // RISC-V base layout, msb first
    struct packed {
      // upper function bits
      logic [6:0] funct7;
      // second source register
      logic [4:0] rs2;
      // first source register
      logic [4:0] rs1;
      // minor function code
      logic [2:0] funct3;
      // destination register
      logic [4:0] rd;
      // major opcode, low 7 bits
      logic [6:0] opcode;
    } ins;
  } rv_word_t;

  // note: compressed encodings are not split out here,
  // a 16-bit fetch shows up in the low half of opcode/rd
  // and the rest are don't care

  // field use per opcode is left to whoever reads the trace,
  // only the fixed positions are given

  // no funct7/rs2 outputs exist yet,
  // they stay in the union for later decode

endpackage

`default_nettype wire

// ==== design/tcb_trace_mon.sv ====
// passive tracer, response delay fixed at one, decode fields zero unless the qualifier is set
`timescale 1ns/1ps
`default_nettype none

`include "tcb_defs.svh"

module tcb_trace_mon (
  tcb_if.mon                 bus,
  // debug qualifiers, sampled with the request
  input  logic               dbg_ifu,
  input  logic               dbg_lsu,
  input  logic               dbg_gpr,
  // trace record
  output logic               trace_vld,
  output logic               trace_wen,
  output logic               trace_err,
  output logic [`TCB_AW-1:0] trace_adr,
  output logic [`TCB_BW-1:0] trace_ben,
  output tcb_pkg::rv_word_t  trace_dat,
  output logic               trace_ifu,
  output logic               trace_lsu,
  output logic               trace_gpr,
  // fetch decode
  output logic [6:0]         trace_opcode,
  output logic [2:0]         trace_funct3,
  output logic [4:0]         trace_rd,
  output logic [4:0]         trace_rs1,
  // gpr index from address
  output logic [4:0]         trace_reg,
  // statistics
  output logic [`TCB_CNT_W-1:0] xfer_cnt,
  output logic [`TCB_CNT_W-1:0] err_cnt
);

  import tcb_pkg::*;

  //////////////////////////////////////////////////
  // delay stage, request held until its response
  //////////////////////////////////////////////////

  // accepted transfer waiting for response
  logic               dly_vld;
  logic               dly_wen;
  logic [`TCB_AW-1:0] dly_adr;
  logic [`TCB_BW-1:0] dly_ben;
  logic [`TCB_DW-1:0] dly_wdt;
  logic               dly_ifu;
  logic               dly_lsu;
  logic               dly_gpr;

  // record data, decoded through the union
  rv_word_t           rec_dat;

  always_ff @(posedge bus.bus) begin
    if (!bus.rst_n) begin
      dly_vld <= 1'b0;
    end else begin
      dly_vld <= bus.vld & bus.rdy;
    end
  end

  // payload only moves on acceptance
  always_ff @(posedge bus.bus) begin
    if (bus.vld && bus.rdy) begin
      dly_wen <= bus.wen;
      dly_adr <= bus.adr;
      dly_ben <= bus.ben;
      dly_wdt <= bus.wdt;
      dly_ifu <= dbg_ifu;
      dly_lsu <= dbg_lsu;
      dly_gpr <= dbg_gpr;
    end
  end

  //////////////////////////////////////////////////
  // record stage
  //////////////////////////////////////////////////

  // writes trace their own data, reads the live rdt
  always_comb begin
    rec_dat.raw = dly_wen ? dly_wdt : bus.rdt;
  end

  // one record per completed transfer
  always_ff @(posedge bus.bus) begin
    if (!bus.rst_n) begin
      trace_vld <= 1'b0;
    end else begin
      trace_vld <= dly_vld;
    end
  end

  always_ff @(posedge bus.bus) begin
    if (dly_vld) begin
      trace_wen <= dly_wen;
      trace_adr <= dly_adr;
      trace_ben <= dly_ben;
      trace_dat <= rec_dat;
      // err is live, same cycle as rdt
      trace_err <= bus.err;
      trace_ifu <= dly_ifu;
      trace_lsu <= dly_lsu;
      trace_gpr <= dly_gpr;
      // instruction fields only for fetches
      trace_opcode <= dly_ifu ? rec_dat.ins.opcode : '0;
      trace_funct3 <= dly_ifu ? rec_dat.ins.funct3 : '0;
      trace_rd     <= dly_ifu ? rec_dat.ins.rd     : '0;
      trace_rs1    <= dly_ifu ? rec_dat.ins.rs1    : '0;
      // register file mapped at word granularity
      trace_reg    <= dly_gpr ? dly_adr[6:2] : '0;
    end
  end

  //////////////////////////////////////////////////
  // statistics
  //////////////////////////////////////////////////

  // same edge as the record, both wrap
  always_ff @(posedge bus.bus) begin
    if (!bus.rst_n) begin
      xfer_cnt <= '0;
      err_cnt  <= '0;
    end else if (dly_vld) begin
      xfer_cnt <= xfer_cnt + 1'b1;
      if (bus.err) begin
        err_cnt <= err_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/tcb_trace_top.sv ====
// one manager on plain ports, trace_vld two edges after acceptance, trace_dat as raw bits
`timescale 1ns/1ps
`default_nettype none

`include "tcb_defs.svh"

module tcb_trace_top (
  input  logic                  bus,
  input  logic                  rst_n,
  // manager request
  input  logic                  vld,
  input  logic                  wen,
  input  logic [`TCB_AW-1:0]    adr,
  input  logic [`TCB_BW-1:0]    ben,
  input  logic [`TCB_DW-1:0]    wdt,
  input  logic                  dbg_ifu,
  input  logic                  dbg_lsu,
  input  logic                  dbg_gpr,
  // bus response
  output logic [`TCB_DW-1:0]    rdt,
  output logic                  err,
  output logic                  rdy,
  // trace record
  output logic                  trace_vld,
  output logic                  trace_wen,
  output logic                  trace_err,
  output logic [`TCB_AW-1:0]    trace_adr,
  output logic [`TCB_BW-1:0]    trace_ben,
  output logic [`TCB_DW-1:0]    trace_dat,
  output logic                  trace_ifu,
  output logic                  trace_lsu,
  output logic                  trace_gpr,
  output logic [6:0]            trace_opcode,
  output logic [2:0]            trace_funct3,
  output logic [4:0]            trace_rd,
  output logic [4:0]            trace_rs1,
  output logic [4:0]            trace_reg,
  output logic [`TCB_CNT_W-1:0] xfer_cnt,
  output logic [`TCB_CNT_W-1:0] err_cnt
);

  // internal bus
  tcb_if tcb (.bus (bus), .rst_n (rst_n));

  // manager side onto the interface
  assign tcb.vld = vld;
  assign tcb.wen = wen;
  assign tcb.adr = adr;
  assign tcb.ben = ben;
  assign tcb.wdt = wdt;

  // response back out
  assign rdt = tcb.rdt;
  assign err = tcb.err;
  assign rdy = tcb.rdy;

  tcb_mem i_mem (.bus (tcb.sub));

  // union output lands on plain bits here
  tcb_trace_mon i_mon (
    .bus (tcb.mon), .dbg_ifu (dbg_ifu), .dbg_lsu (dbg_lsu), .dbg_gpr (dbg_gpr),
    .trace_vld (trace_vld), .trace_wen (trace_wen), .trace_err (trace_err),
    .trace_adr (trace_adr), .trace_ben (trace_ben), .trace_dat (trace_dat),
    .trace_ifu (trace_ifu), .trace_lsu (trace_lsu), .trace_gpr (trace_gpr),
    .trace_opcode (trace_opcode), .trace_funct3 (trace_funct3),
    .trace_rd (trace_rd), .trace_rs1 (trace_rs1), .trace_reg (trace_reg),
    .xfer_cnt (xfer_cnt), .err_cnt (err_cnt)
  );

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+design
design/tcb_pkg.sv
design/tcb_if.sv
design/tcb_mem.sv
design/tcb_trace_mon.sv
design/tcb_trace_top.sv
verification/tcb_trace_checker.sv
verification/tcb_trace_tb.sv

// ==== verification/tcb_trace_checker.sv ====
// bound into the top level; assumes one manager and synchronous active low reset on rst_n
`timescale 1ns/1ps
`default_nettype none

`include "tcb_defs.svh"

module tcb_trace_checker (
  input logic               bus,
  input logic               rst_n,
  input logic               vld,
  input logic               wen,
  input logic [`TCB_AW-1:0] adr,
  input logic [`TCB_BW-1:0] ben,
  input logic [`TCB_DW-1:0] wdt,
  input logic               rdy,
  input logic               trace_vld
);

  // failed assertions so far, read by the testbench
  int unsigned fail_cnt = 0;

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  // write turnaround, one cycle of rdy low
  a_turnaround: assert property (@(posedge bus) disable iff (!rst_n)
    (vld && rdy && wen) |=> !rdy)
  else begin
    $error("rdy stayed high in the cycle after an accepted write");
    fail_cnt++;
  end

  // held request may not move
  a_hold: assert property (@(posedge bus) disable iff (!rst_n)
    (vld && !rdy) |=> (vld && $stable(wen) && $stable(adr) && $stable(ben) && $stable(wdt)))
  else begin
    $error("request changed or dropped while rdy was low");
    fail_cnt++;
  end

  //////////////////////////////////////////////////
  // trace timing
  //////////////////////////////////////////////////

  // record two edges after acceptance
  a_latency: assert property (@(posedge bus) disable iff (!rst_n)
    (vld && rdy) |-> ##2 trace_vld)
  else begin
    $error("no trace record two edges after an accepted transfer");
    fail_cnt++;
  end

  // reset clears the record valid
  a_reset: assert property (@(posedge bus) !rst_n |=> !trace_vld)
  else begin
    $error("trace_vld high while reset was applied");
    fail_cnt++;
  end

endmodule

bind tcb_trace_top tcb_trace_checker i_chk (
  .bus (bus), .rst_n (rst_n), .vld (vld), .wen (wen), .adr (adr),
  .ben (ben), .wdt (wdt), .rdy (rdy), .trace_vld (trace_vld)
);

`default_nettype wire

// ==== verification/tcb_trace_tb.sv ====
// single manager on the top level ports; memory words are read back only after a full-word write
`timescale 1ns/1ps
`default_nettype none

`include "tcb_defs.svh"

module tcb_trace_tb;

  // transfers per test
  localparam int N_RAND = 8;
  localparam int N_PAIR = 4;
  localparam int N_OOB  = 2;
  localparam int N_INS  = 4;
  localparam int N_GPR  = 6;
  localparam int N_XFER = 3*N_RAND + 2*N_PAIR + 3*N_OOB + 3*N_INS + 2*N_GPR;
  // two cycles per transfer at most, doubled, plus reset and drain
  localparam int LIMIT  = 4*N_XFER + 100;
  // addi, sw, jal, sub
  localparam logic [31:0] INS_WORD [N_INS] =
    '{32'h00a2_8293, 32'h0062_a023, 32'hfe5f_f0ef, 32'h40b5_0533};

  // manager side
  logic                  bus;
  logic                  rst_n;
  logic                  vld, wen, dbg_ifu, dbg_lsu, dbg_gpr;
  logic [`TCB_AW-1:0]    adr;
  logic [`TCB_BW-1:0]    ben;
  logic [`TCB_DW-1:0]    wdt;
  // response and trace record
  logic [`TCB_DW-1:0]    rdt, trace_dat;
  logic                  err, rdy, trace_vld, trace_wen, trace_err;
  logic                  trace_ifu, trace_lsu, trace_gpr;
  logic [`TCB_AW-1:0]    trace_adr;
  logic [`TCB_BW-1:0]    trace_ben;
  logic [6:0]            trace_opcode;
  logic [2:0]            trace_funct3;
  logic [4:0]            trace_rd, trace_rs1, trace_reg;
  logic [`TCB_CNT_W-1:0] xfer_cnt, err_cnt;

  // reference memory keyed by word index
  logic [`TCB_DW-1:0] model [logic [`TCB_AW-3:0]];
  // {ifu, lsu, gpr, wen, err, ben, adr, dat}
  logic [5+`TCB_BW+`TCB_AW+`TCB_DW-1:0] exp_q [$];
  // {err, rdt} owed on the bus response in acceptance order
  logic [`TCB_DW:0] resp_q [$];
  // handshake seen on the last rising edge
  logic acc_seen;
  logic [`TCB_AW-1:0] rand_adr [N_RAND];
  logic [`TCB_AW-1:0] gpr_adr [N_GPR];
  int unsigned errors, checks, rec_cnt, err_exp, last_wait;
  int unsigned tests_run, tests_bad, test_err0, cycles;

  tcb_trace_top i_dut (.*);

  initial begin
    bus = 1'b0;
    forever #2 bus = ~bus;
  end

  // run limit in clock cycles
  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge bus);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", LIMIT);
    $display(">>> FAIL");
    $finish;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic int unsigned fail_total();
    return errors + i_dut.i_chk.fail_cnt;
  endfunction

  function automatic logic [`TCB_AW-1:0] word_adr(input int unsigned idx, input logic [31:0] r);
    // random byte offset the memory ignores
    return {idx[`TCB_AW-3:0], r[1:0]};
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[FAIL] %0t ns %s got %h expected %h", $time, what, got, exp);
    errors++;
  endtask

  // one request held through stalls and scoreboarded at acceptance
  task automatic drive_xfer(input logic w, input logic [`TCB_AW-1:0] a,
                            input logic [`TCB_BW-1:0] be, input logic [`TCB_DW-1:0] d,
                            input logic ifu, input logic lsu, input logic gpr);
    logic [`TCB_AW-3:0] wrd;
    logic               oob;
    logic [`TCB_DW-1:0] dat;
    logic [`TCB_DW-1:0] rsp;
    @(negedge bus);
    vld = 1'b1;
    wen = w;
    adr = a;
    ben = be;
    wdt = d;
    dbg_ifu = ifu;
    dbg_lsu = lsu;
    dbg_gpr = gpr;
    last_wait = 0;
    while (!rdy) begin
      @(negedge bus);
      last_wait++;
    end
    // rdy high here so taken on the next rising edge
    wrd = a[`TCB_AW-1:2];
    oob = (wrd >= `TCB_MEM_WORDS);
    if (w && !oob) begin
      if (!model.exists(wrd)) begin
        model[wrd] = 'x;
      end
      for (int b = 0; b < `TCB_BW; b++) begin
        if (be[b]) begin
          model[wrd][8*b +: 8] = d[8*b +: 8];
        end
      end
    end
    // writes trace wdt and errored reads zero
    if (w) begin
      dat = d;
    end else if (oob) begin
      dat = '0;
    end else begin
      dat = model.exists(wrd) ? model[wrd] : 'x;
    end
    exp_q.push_back({ifu, lsu, gpr, w, oob, be, a, dat});
    // bus rdt carries data only for in range reads
    rsp = w ? '0 : dat;
    resp_q.push_back({oob, rsp});
  endtask

  task automatic wait_drain();
    @(negedge bus);
    vld = 1'b0;
    while (exp_q.size() != 0 || resp_q.size() != 0) begin
      @(negedge bus);
    end
    @(negedge bus);
  endtask

  task automatic finish_test(input string name);
    wait_drain();
    tests_run++;
    if (fail_total() == test_err0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      $display("test %0d %s: %0d errors", tests_run, name, fail_total() - test_err0);
      tests_bad++;
    end
    test_err0 = fail_total();
  endtask

  //////////////////////////////////////////////////
  // bus response check on the falling edge
  //////////////////////////////////////////////////

  task automatic check_response();
    logic               e_err;
    logic [`TCB_DW-1:0] e_rdt;
    if (resp_q.size() == 0) begin
      $display("bus response at %0t ns without an accepted transfer behind it", $time);
      errors++;
    end else begin
      {e_err, e_rdt} = resp_q.pop_front();
      assert (rdt === e_rdt) else report_mismatch("rdt", rdt, e_rdt);
      assert (err === e_err) else report_mismatch("err", err, e_err);
    end
  endtask

  always @(posedge bus) begin
    acc_seen <= (vld === 1'b1) && (rdy === 1'b1);
  end

  always @(negedge bus) begin
    if (acc_seen === 1'b1) begin
      check_response();
    end
  end

  //////////////////////////////////////////////////
  // record check on the falling edge
  //////////////////////////////////////////////////

  task automatic check_record();
    logic               e_ifu, e_lsu, e_gpr, e_wen, e_err;
    logic [`TCB_BW-1:0] e_ben;
    logic [`TCB_AW-1:0] e_adr;
    logic [`TCB_DW-1:0] e_dat;
    if (exp_q.size() == 0) begin
      $display("trace record at %0t ns without an accepted transfer behind it", $time);
      errors++;
    end else begin
      {e_ifu, e_lsu, e_gpr, e_wen, e_err, e_ben, e_adr, e_dat} = exp_q.pop_front();
      rec_cnt++;
      err_exp += e_err;
      checks++;
      assert (trace_wen === e_wen) else report_mismatch("trace_wen", trace_wen, e_wen);
      assert (trace_err === e_err) else report_mismatch("trace_err", trace_err, e_err);
      assert (trace_adr === e_adr) else report_mismatch("trace_adr", trace_adr, e_adr);
      assert (trace_ben === e_ben) else report_mismatch("trace_ben", trace_ben, e_ben);
      assert (trace_dat === e_dat) else report_mismatch("trace_dat", trace_dat, e_dat);
      assert (trace_ifu === e_ifu) else report_mismatch("trace_ifu", trace_ifu, e_ifu);
      assert (trace_lsu === e_lsu) else report_mismatch("trace_lsu", trace_lsu, e_lsu);
      assert (trace_gpr === e_gpr) else report_mismatch("trace_gpr", trace_gpr, e_gpr);
      // RV base fields are zero unless fetched
      assert (trace_opcode === (e_ifu ? e_dat[6:0] : 7'd0))
        else report_mismatch("trace_opcode", trace_opcode, e_ifu ? e_dat[6:0] : 7'd0);
      assert (trace_rd === (e_ifu ? e_dat[11:7] : 5'd0))
        else report_mismatch("trace_rd", trace_rd, e_ifu ? e_dat[11:7] : 5'd0);
      assert (trace_funct3 === (e_ifu ? e_dat[14:12] : 3'd0))
        else report_mismatch("trace_funct3", trace_funct3, e_ifu ? e_dat[14:12] : 3'd0);
      assert (trace_rs1 === (e_ifu ? e_dat[19:15] : 5'd0))
        else report_mismatch("trace_rs1", trace_rs1, e_ifu ? e_dat[19:15] : 5'd0);
      // register index from word address
      assert (trace_reg === (e_gpr ? e_adr[6:2] : 5'd0))
        else report_mismatch("trace_reg", trace_reg, e_gpr ? e_adr[6:2] : 5'd0);
      assert (xfer_cnt === rec_cnt[`TCB_CNT_W-1:0])
        else report_mismatch("xfer_cnt", xfer_cnt, rec_cnt);
      assert (err_cnt === err_exp[`TCB_CNT_W-1:0])
        else report_mismatch("err_cnt", err_cnt, err_exp);
    end
  endtask

  always @(negedge bus) begin
    if (rst_n === 1'b1 && trace_vld === 1'b1) begin
      check_record();
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    logic [31:0]        rnd;
    logic [`TCB_AW-1:0] a;
    void'($urandom(32'h81d0_b44e));
    {rst_n, vld, wen, dbg_ifu, dbg_lsu, dbg_gpr} = '0;
    adr = '0;
    ben = '0;
    wdt = '0;
    {errors, checks, rec_cnt, err_exp, last_wait} = '0;
    {tests_run, tests_bad, test_err0} = '0;
    repeat (2) @(posedge bus);
    @(negedge bus);
    rst_n = 1'b1;

    // idle state after reset
    @(negedge bus);
    assert (trace_vld === 1'b0) else report_mismatch("trace_vld after reset", trace_vld, 0);
    assert (rdy === 1'b1) else report_mismatch("rdy after reset", rdy, 1);
    assert (xfer_cnt === '0) else report_mismatch("xfer_cnt after reset", xfer_cnt, 0);
    assert (err_cnt === '0) else report_mismatch("err_cnt after reset", err_cnt, 0);
    finish_test("reset state");

    // full words first and then random lanes over them
    for (int i = 0; i < N_RAND; i++) begin
      rnd = $urandom;
      rand_adr[i] = word_adr($urandom_range(`TCB_MEM_WORDS-1, 0), rnd);
      drive_xfer(1'b1, rand_adr[i], '1, $urandom, 1'b0, 1'b0, 1'b0);
    end
    for (int i = 0; i < N_RAND; i++) begin
      rnd = $urandom;
      drive_xfer(1'b1, rand_adr[i], rnd[`TCB_BW-1:0], $urandom, 1'b0, 1'b0, 1'b0);
    end
    for (int i = 0; i < N_RAND; i++) begin
      drive_xfer(1'b0, rand_adr[i], '1, '0, 1'b0, 1'b0, 1'b0);
    end
    finish_test("byte enable write and read");

    // read right behind a write waits out the turnaround
    for (int i = 0; i < N_PAIR; i++) begin
      rnd = $urandom;
      a = word_adr($urandom_range(`TCB_MEM_WORDS-1, 0), rnd);
      drive_xfer(1'b1, a, '1, $urandom, 1'b0, 1'b0, 1'b0);
      drive_xfer(1'b0, a, '1, '0, 1'b0, 1'b0, 1'b0);
      assert (last_wait == 1) else report_mismatch("read hold cycles", last_wait, 1);
    end
    finish_test("write turnaround");

    // aliases of known words one range above
    for (int i = 0; i < N_OOB; i++) begin
      rnd = $urandom;
      drive_xfer(1'b1, rand_adr[i] + `TCB_MEM_WORDS*4, '1, $urandom, 1'b0, 1'b0, 1'b0);
      drive_xfer(1'b0, rnd | `TCB_MEM_WORDS*4, '1, '0, 1'b0, 1'b0, 1'b0);
      drive_xfer(1'b0, rand_adr[i], '1, '0, 1'b0, 1'b0, 1'b0);
    end
    finish_test("range error");

    // same words fetched and then loaded
    for (int i = 0; i < N_INS; i++) begin
      drive_xfer(1'b1, 32'h100 + 4*i, '1, INS_WORD[i], 1'b0, 1'b0, 1'b0);
    end
    for (int i = 0; i < N_INS; i++) begin
      drive_xfer(1'b0, 32'h100 + 4*i, '1, '0, 1'b1, 1'b0, 1'b0);
    end
    for (int i = 0; i < N_INS; i++) begin
      drive_xfer(1'b0, 32'h100 + 4*i, '1, '0, 1'b0, 1'b1, 1'b0);
    end
    finish_test("fetch decode");

    // register file window at 0x200
    for (int i = 0; i < N_GPR; i++) begin
      rnd = $urandom;
      gpr_adr[i] = 32'h200 | {rnd[4:0], 2'b00};
      drive_xfer(1'b1, gpr_adr[i], '1, $urandom, 1'b0, rnd[5], 1'b1);
    end
    for (int i = 0; i < N_GPR; i++) begin
      rnd = $urandom;
      drive_xfer(1'b0, gpr_adr[i], '1, '0, 1'b0, rnd[5], 1'b1);
    end
    finish_test("gpr and lsu qualifiers");

    $display("%0d tests, %0d failed, %0d records checked, %0d errors",
             tests_run, tests_bad, checks, fail_total());
    if (fail_total() == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
